// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --timescale 1ns/1ps -f verilog.f \
  --top-module tb_cpu_system -o tb_cpu_system > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_cpu_system > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && exit 0 || { echo "Simulation did not finish"; exit 1; }

// File: sim/tb_programs.svh
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Program bytes are hex from address 0, space separated
// Writes that follow a row are its expected (address, data) pairs in order
task automatic build_table();
  // LD A,d8 then LD H,d8 and LD L,d8, store A through HL, HALT
  add_row("ld_store", "3E 5A 26 00 2E 41 77 76");
  add_write(16'h0041, 8'h5A);

  // High byte of HL lies beyond the 256-byte memory
  add_row("ld_store_wrap", "3E A7 26 12 2E 45 77 76");
  add_write(16'h1245, 8'hA7);

  // ALU rows load A and B, run one op and store A
  add_row("add_basic", "3E 12 06 34 26 00 2E 42 80 77 76");
  add_write(16'h0042, 8'h46);
  add_row("add_overflow", "3E F0 06 25 26 00 2E 43 80 77 76");
  add_write(16'h0043, 8'h15);  // Carry out of bit 7 dropped
  add_row("sub_basic", "3E 50 06 21 26 00 2E 44 90 77 76");
  add_write(16'h0044, 8'h2F);
  add_row("sub_to_zero", "3E 7C 06 7C 26 00 2E 45 90 77 76");
  add_write(16'h0045, 8'h00);
  add_row("and_mask", "3E CC 06 0F 26 00 2E 46 A0 77 76");
  add_write(16'h0046, 8'h0C);
  add_row("xor_invert", "3E A5 06 FF 26 00 2E 47 A8 77 76");
  add_write(16'h0047, 8'h5A);

  // Count down from 3, JR NZ at 0A jumps back to the SUB at 08
  add_row("jr_nz_loop", "3E 03 06 01 26 00 2E 40 90 77 20 FC 76");
  add_write(16'h0040, 8'h02);
  add_write(16'h0040, 8'h01);
  add_write(16'h0040, 8'h00);  // Z set, falls through to HALT

  // FF and D3 are not in the opcode map
  add_row("unknown_nop", "3E 33 26 00 2E 48 FF D3 00 77 76");
  add_write(16'h0048, 8'h33);
endtask

`endif

// File: sim/tb_cpu_system.sv
`timescale 1ns/1ps

module tb_cpu_system;

  localparam int          MEM_ADDR_WIDTH = 8;
  localparam logic [15:0] ADDR_MASK      = 16'((1 << MEM_ADDR_WIDTH) - 1);
  localparam int          MAX_ROWS       = 24;
  localparam int          PROG_BYTES     = 16;
  localparam int          DATA_FIRST     = 'h40;  // Data area cleared before each run
  localparam int          DATA_LAST      = 'h5F;
  localparam int          LOAD_TIMEOUT   = 20;
  localparam int          RUN_TIMEOUT    = 400;

  logic        clk;
  logic        reset;
  logic        load_valid;
  logic        load_ready;
  logic [15:0] load_addr;
  logic [7:0]  load_data;
  logic        wr_en;
  logic [15:0] wr_addr;
  logic [7:0]  wr_data;
  logic        halted;

  // Stimulus table
  string       row_name   [MAX_ROWS];
  logic [7:0]  row_prog   [MAX_ROWS][PROG_BYTES];
  int          row_writes [MAX_ROWS];
  logic [15:0] row_addr   [MAX_ROWS][4];
  logic [7:0]  row_data   [MAX_ROWS][4];
  int          num_rows;

  // Writes seen on the monitor during one run
  logic [15:0] seen_addr [8];
  logic [7:0]  seen_data [8];
  int          seen_count;

  cpu_system #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) cpu_system_inst (
    .clk        (clk),
    .reset      (reset),
    .load_valid (load_valid),
    .load_ready (load_ready),
    .load_addr  (load_addr),
    .load_data  (load_data),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .halted     (halted)
  );

  always #50 clk = ~clk;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
      stop_with_error($sformatf("FAIL %s expected %0h actual %0h", name, expected, actual));
  endtask

  task automatic add_row(input string name, input string prog);
    int    count;
    int    k;
    string byte_str;
    count = (prog.len() + 1) / 3;
    row_name[num_rows]   = name;
    row_writes[num_rows] = 0;
    for (k = 0; k < PROG_BYTES; k++) begin
      if (k < count) begin
        byte_str = prog.substr(3 * k, 3 * k + 1);
        row_prog[num_rows][k] = 8'(byte_str.atohex());
      end else begin
        row_prog[num_rows][k] = 8'h76;  // Pad with HALT
      end
    end
    num_rows++;
  endtask

  task automatic add_write(input logic [15:0] addr, input logic [7:0] data);
    int r;
    r = num_rows - 1;
    row_addr[r][row_writes[r]] = addr;
    row_data[r][row_writes[r]] = data;
    row_writes[r]++;
  endtask

  // Expected A after one ALU opcode
  function automatic logic [7:0] alu_model(input logic [7:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
    case (op)
      8'h80:   return a + b;
      8'h90:   return a - b;
      8'hA0:   return a & b;
      default: return a ^ b;
    endcase
  endfunction

  `include "tb_programs.svh"

  task automatic add_random_rows();
    int         i;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] op;
    logic [7:0] lo;
    for (i = 0; i < 8; i++) begin
      a = 8'($urandom);
      b = 8'($urandom);
      case (2'($urandom))
        2'd0:    op = 8'h80;
        2'd1:    op = 8'h90;
        2'd2:    op = 8'hA0;
        default: op = 8'hA8;
      endcase
      lo = 8'h50 + 8'(i);  // One result byte per row
      add_row($sformatf("random_%0d", i),
              $sformatf("3E %02h 06 %02h 26 00 2E %02h %02h 77 76", a, b, lo, op));
      add_write({8'h00, lo}, alu_model(op, a, b));
    end
  endtask

  // Called on a falling edge, returns on the falling edge after the transfer
  task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
    int waited;
    waited     = 0;
    load_addr  = addr;
    load_data  = data;
    load_valid = 1'b1;
    while (!load_ready) begin
      @(negedge clk);
      waited++;
      if (waited > LOAD_TIMEOUT)
        stop_with_error($sformatf("Timeout: load port not ready for address %0h", addr));
    end
    @(negedge clk);
    load_valid = 1'b0;
  endtask

  task automatic check_reset_idle();
    int c;
    reset = 1'b1;
    repeat (8) @(negedge clk);
    for (c = 0; c < 20; c++) begin
      @(negedge clk);
      check_value("reset_idle wr_en", 0, 32'(wr_en));
      check_value("reset_idle halted", 0, 32'(halted));
      check_value("reset_idle load_ready", 1, 32'(load_ready));
    end
  endtask

  task automatic run_row(input int r);
    int k;
    int cycles;
    reset = 1'b1;
    repeat (8) @(negedge clk);
    for (k = 0; k < PROG_BYTES; k++)
      load_byte(16'(k), row_prog[r][k]);
    for (k = DATA_FIRST; k <= DATA_LAST; k++)
      load_byte(16'(k), 8'h00);
    seen_count = 0;
    cycles     = 0;
    reset      = 1'b0;
    while (!halted) begin
      @(negedge clk);
      if (wr_en) begin
        if (seen_count < 8) begin
          seen_addr[seen_count] = wr_addr;
          seen_data[seen_count] = wr_data;
        end
        seen_count++;
      end
      cycles++;
      if (cycles > RUN_TIMEOUT)
        stop_with_error($sformatf("Timeout: %s did not halt within %0d cycles",
                                  row_name[r], RUN_TIMEOUT));
    end
    check_value({row_name[r], " write count"}, row_writes[r], seen_count);
    for (k = 0; k < seen_count; k++) begin
      // HL wraps modulo the memory size
      check_value($sformatf("%s write %0d addr", row_name[r], k),
                  32'(row_addr[r][k] & ADDR_MASK), 32'(seen_addr[k]));
      check_value($sformatf("%s write %0d data", row_name[r], k),
                  32'(row_data[r][k]), 32'(seen_data[k]));
    end
  endtask

  initial begin
    int r;
    clk        = 1'b0;
    reset      = 1'b1;
    load_valid = 1'b0;
    load_addr  = 16'h0000;
    load_data  = 8'h00;
    num_rows   = 0;
    void'($urandom(32'h7c20_3f58));
    build_table();
    add_random_rows();
    check_reset_idle();
    for (r = 0; r < num_rows; r++)
      run_row(r);
    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+sim
verilog/cpu_pkg.sv
verilog/cpu_control_rom.sv
verilog/cpu_alu.sv
verilog/cpu_core.sv
verilog/system_memory.sv
verilog/cpu_system.sv
sim/tb_cpu_system.sv

// File: verilog/cpu_alu.sv
`timescale 1ns/1ps

module cpu_alu (
  input  cpu_pkg::alu_op_t alu_op,
  input  logic [7:0]       a,
  input  logic [7:0]       b,
  output logic [7:0]       result,
  output logic             zero_flag,
  output logic             carry_flag
);

  logic [8:0] sum;
  logic [8:0] diff;

  assign sum  = {1'b0, a} + {1'b0, b};
  assign diff = {1'b0, a} - {1'b0, b};  // Bit 8 is the borrow

  always_comb begin
    case (alu_op)
      cpu_pkg::ALU_ADD: begin
        result     = sum[7:0];
        carry_flag = sum[8];
      end
      cpu_pkg::ALU_SUB: begin
        result     = diff[7:0];
        carry_flag = diff[8];
      end
      cpu_pkg::ALU_AND: begin
        result     = a & b;
        carry_flag = 1'b0;
      end
      cpu_pkg::ALU_XOR: begin
        result     = a ^ b;
        carry_flag = 1'b0;
      end
      default: begin
        result     = a;  // Pass A through
        carry_flag = 1'b0;
      end
    endcase
  end

  assign zero_flag = (result == 8'h00);

endmodule

// File: verilog/cpu_control_rom.sv
`timescale 1ns/1ps

module cpu_control_rom (
  input  cpu_pkg::opcode_t      opcode,
  input  cpu_pkg::cycle_count_t cycle_count,
  output cpu_pkg::addr_src_t    addr_src,
  output cpu_pkg::data_bus_op_t data_bus_op,
  output cpu_pkg::reg_sel_t     data_reg,
  output cpu_pkg::idu_op_t      idu_op,
  output cpu_pkg::alu_op_t      alu_op,
  output cpu_pkg::misc_op_t     misc_op,
  output cpu_pkg::cond_t        cond,
  output logic                  last_cycle
);

  localparam cpu_pkg::cycle_count_t LAST_INDEX =
    cpu_pkg::cycle_count_t'(cpu_pkg::MAX_CYCLES_PER_INSTR - 1);

  always_comb begin
    // Idle cycle that ends the instruction
    addr_src    = cpu_pkg::ADDR_NONE;
    data_bus_op = cpu_pkg::DATA_BUS_OP_NONE;
    data_reg    = cpu_pkg::REG_Z;
    idu_op      = cpu_pkg::IDU_NONE;
    alu_op      = cpu_pkg::ALU_NONE;
    misc_op     = cpu_pkg::MISC_NONE;
    cond        = cpu_pkg::COND_ALWAYS;
    last_cycle  = 1'b1;

    case (cycle_count)
      2'd0: begin
        // Opcode fetch, same for every instruction
        addr_src    = cpu_pkg::ADDR_PC;
        data_bus_op = cpu_pkg::DATA_BUS_OP_READ;
        data_reg    = cpu_pkg::REG_IR;
        idu_op      = cpu_pkg::IDU_INC;
        case (opcode)
          cpu_pkg::OP_ADD_A_B: alu_op = cpu_pkg::ALU_ADD;
          cpu_pkg::OP_SUB_A_B: alu_op = cpu_pkg::ALU_SUB;
          cpu_pkg::OP_AND_A_B: alu_op = cpu_pkg::ALU_AND;
          cpu_pkg::OP_XOR_A_B: alu_op = cpu_pkg::ALU_XOR;
          cpu_pkg::OP_HALT:    misc_op = cpu_pkg::MISC_HALT;
          cpu_pkg::OP_LD_A_D8, cpu_pkg::OP_LD_B_D8, cpu_pkg::OP_LD_H_D8,
          cpu_pkg::OP_LD_L_D8, cpu_pkg::OP_LD_HL_A, cpu_pkg::OP_JR_NZ:
            last_cycle = 1'b0;
          default: ;  // NOP and unknown opcodes
        endcase
      end
      2'd1: begin
        case (opcode)
          cpu_pkg::OP_LD_A_D8, cpu_pkg::OP_LD_B_D8, cpu_pkg::OP_LD_H_D8,
          cpu_pkg::OP_LD_L_D8, cpu_pkg::OP_JR_NZ: begin
            addr_src    = cpu_pkg::ADDR_PC;  // Immediate byte follows opcode
            data_bus_op = cpu_pkg::DATA_BUS_OP_READ;
            idu_op      = cpu_pkg::IDU_INC;
          end
          cpu_pkg::OP_LD_HL_A: begin
            addr_src    = cpu_pkg::ADDR_HL;
            data_bus_op = cpu_pkg::DATA_BUS_OP_WRITE;
            data_reg    = cpu_pkg::REG_A;
          end
          default: ;
        endcase
        case (opcode)
          cpu_pkg::OP_LD_A_D8: data_reg = cpu_pkg::REG_A;
          cpu_pkg::OP_LD_B_D8: data_reg = cpu_pkg::REG_B;
          cpu_pkg::OP_LD_H_D8: data_reg = cpu_pkg::REG_H;
          cpu_pkg::OP_LD_L_D8: data_reg = cpu_pkg::REG_L;
          cpu_pkg::OP_JR_NZ: begin
            data_reg   = cpu_pkg::REG_Z;  // Offset into temporary
            misc_op    = cpu_pkg::MISC_COND_CHECK;
            cond       = cpu_pkg::COND_NZ;
            last_cycle = 1'b0;
          end
          default: ;
        endcase
      end
      2'd2: begin
        if (opcode == cpu_pkg::OP_JR_NZ)
          misc_op = cpu_pkg::MISC_JUMP_REL;
      end
      default: ;
    endcase

    // No instruction runs past the longest one
    if (cycle_count >= LAST_INDEX)
      last_cycle = 1'b1;
  end

endmodule

// File: verilog/cpu_core.sv
`timescale 1ns/1ps

module cpu_core (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  output logic        mmu_req_read,
  output logic        mmu_req_write,
  output logic        halted
);

  logic [15:0]           pc;
  cpu_pkg::opcode_t      ir;
  logic [7:0]            reg_a;
  logic [7:0]            reg_b;
  logic [7:0]            reg_h;
  logic [7:0]            reg_l;
  logic [7:0]            reg_z;  // Temporary operand
  logic                  flag_z;
  logic                  flag_c;

  cpu_pkg::t_phase_t     t_phase;
  cpu_pkg::cycle_count_t cycle_count;
  cpu_pkg::opcode_t      opcode;

  cpu_pkg::addr_src_t    addr_src;
  cpu_pkg::data_bus_op_t data_bus_op;
  cpu_pkg::reg_sel_t     data_reg;
  cpu_pkg::idu_op_t      idu_op;
  cpu_pkg::alu_op_t      alu_op;
  cpu_pkg::misc_op_t     misc_op;
  cpu_pkg::cond_t        cond;
  logic                  last_cycle;

  logic [7:0]            alu_result;
  logic                  alu_zero;
  logic                  alu_carry;
  logic                  cond_met;
  logic [7:0]            wdata;

  // During the opcode capture the new byte is still on the bus
  assign opcode = (cycle_count == '0 && t_phase == cpu_pkg::T3) ?
                  cpu_pkg::opcode_t'(data_bus) : ir;

  cpu_control_rom control_rom_inst (
    .opcode      (opcode),
    .cycle_count (cycle_count),
    .addr_src    (addr_src),
    .data_bus_op (data_bus_op),
    .data_reg    (data_reg),
    .idu_op      (idu_op),
    .alu_op      (alu_op),
    .misc_op     (misc_op),
    .cond        (cond),
    .last_cycle  (last_cycle)
  );

  cpu_alu alu_inst (
    .alu_op     (alu_op),
    .a          (reg_a),
    .b          (reg_b),
    .result     (alu_result),
    .zero_flag  (alu_zero),
    .carry_flag (alu_carry)
  );

  assign cond_met = (cond == cpu_pkg::COND_ALWAYS) || !flag_z;

  // Write source select
  always_comb begin
    case (data_reg)
      cpu_pkg::REG_A:  wdata = reg_a;
      cpu_pkg::REG_B:  wdata = reg_b;
      cpu_pkg::REG_H:  wdata = reg_h;
      cpu_pkg::REG_L:  wdata = reg_l;
      cpu_pkg::REG_IR: wdata = ir;
      default:         wdata = reg_z;
    endcase
  end

  // Core drives the bus only while its write request is up
  assign data_bus = mmu_req_write ? wdata : 8'bz;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc            <= 16'h0000;
      ir            <= cpu_pkg::OP_NOP;
      addr_bus      <= 16'h0000;
      mmu_req_read  <= 1'b0;
      mmu_req_write <= 1'b0;
      halted        <= 1'b0;
      flag_z        <= 1'b0;
      flag_c        <= 1'b0;
      t_phase       <= cpu_pkg::T1;
      cycle_count   <= '0;
    end else if (!halted) begin
      unique case (t_phase)
        cpu_pkg::T1: begin
          case (addr_src)
            cpu_pkg::ADDR_PC: addr_bus <= pc;
            cpu_pkg::ADDR_HL: addr_bus <= {reg_h, reg_l};
            default: ;  // Hold last address
          endcase
          t_phase <= cpu_pkg::T2;
        end
        cpu_pkg::T2: begin
          mmu_req_read  <= (data_bus_op == cpu_pkg::DATA_BUS_OP_READ);
          mmu_req_write <= (data_bus_op == cpu_pkg::DATA_BUS_OP_WRITE);
          t_phase       <= cpu_pkg::T3;
        end
        cpu_pkg::T3: begin
          if (data_bus_op == cpu_pkg::DATA_BUS_OP_READ && data_reg == cpu_pkg::REG_IR)
            ir <= cpu_pkg::opcode_t'(data_bus);
          t_phase <= cpu_pkg::T4;
        end
        cpu_pkg::T4: begin
          mmu_req_read  <= 1'b0;
          mmu_req_write <= 1'b0;

          if (idu_op == cpu_pkg::IDU_INC)
            pc <= pc + 16'd1;
          else if (misc_op == cpu_pkg::MISC_JUMP_REL)
            pc <= pc + {{8{reg_z[7]}}, reg_z};

          if (alu_op != cpu_pkg::ALU_NONE) begin
            flag_z <= alu_zero;
            flag_c <= alu_carry;
          end

          if (misc_op == cpu_pkg::MISC_HALT)
            halted <= 1'b1;

          // A failed condition ends the instruction here
          if (last_cycle || (misc_op == cpu_pkg::MISC_COND_CHECK && !cond_met))
            cycle_count <= '0;
          else
            cycle_count <= cycle_count + 2'd1;

          t_phase <= cpu_pkg::T1;
        end
      endcase
    end
  end

  // Data registers, loaded from the bus in T3 or from the ALU in T4
  always_ff @(posedge clk) begin
    if (!reset && !halted) begin
      if (t_phase == cpu_pkg::T3 && data_bus_op == cpu_pkg::DATA_BUS_OP_READ) begin
        case (data_reg)
          cpu_pkg::REG_A: reg_a <= data_bus;
          cpu_pkg::REG_B: reg_b <= data_bus;
          cpu_pkg::REG_H: reg_h <= data_bus;
          cpu_pkg::REG_L: reg_l <= data_bus;
          cpu_pkg::REG_Z: reg_z <= data_bus;
          default: ;  // IR handled with control state
        endcase
      end
      if (t_phase == cpu_pkg::T4 && alu_op != cpu_pkg::ALU_NONE)
        reg_a <= alu_result;
    end
  end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

  // Clock phase within a machine cycle
  typedef enum logic [1:0] {
    T1 = 2'd0,
    T2 = 2'd1,
    T3 = 2'd2,
    T4 = 2'd3
  } t_phase_t;

  // Where the address for this machine cycle comes from
  typedef enum logic [1:0] {
    ADDR_PC   = 2'd0,
    ADDR_HL   = 2'd1,
    ADDR_NONE = 2'd2  // Keep previous address, no access
  } addr_src_t;

  typedef enum logic [1:0] {
    DATA_BUS_OP_NONE  = 2'd0,
    DATA_BUS_OP_READ  = 2'd1,
    DATA_BUS_OP_WRITE = 2'd2
  } data_bus_op_t;

  // Read destination or write source of a bus access
  typedef enum logic [2:0] {
    REG_A  = 3'd0,
    REG_B  = 3'd1,
    REG_H  = 3'd2,
    REG_L  = 3'd3,
    REG_IR = 3'd4,
    REG_Z  = 3'd5  // Temporary operand
  } reg_sel_t;

  // Increment applied to PC after an access
  typedef enum logic {
    IDU_NONE = 1'b0,
    IDU_INC  = 1'b1
  } idu_op_t;

  typedef enum logic [2:0] {
    ALU_NONE = 3'd0,
    ALU_ADD  = 3'd1,
    ALU_SUB  = 3'd2,
    ALU_AND  = 3'd3,
    ALU_XOR  = 3'd4
  } alu_op_t;

  typedef enum logic [1:0] {
    MISC_NONE       = 2'd0,
    MISC_COND_CHECK = 2'd1,  // End instruction early if condition false
    MISC_JUMP_REL   = 2'd2,  // PC += sign-extended Z
    MISC_HALT       = 2'd3
  } misc_op_t;

  typedef enum logic {
    COND_NZ     = 1'b0,
    COND_ALWAYS = 1'b1
  } cond_t;

  // Supported opcodes; anything else runs as NOP
  typedef enum logic [7:0] {
    OP_NOP     = 8'h00,
    OP_LD_B_D8 = 8'h06,
    OP_JR_NZ   = 8'h20,
    OP_LD_H_D8 = 8'h26,
    OP_LD_L_D8 = 8'h2E,
    OP_LD_A_D8 = 8'h3E,
    OP_HALT    = 8'h76,
    OP_LD_HL_A = 8'h77,
    OP_ADD_A_B = 8'h80,
    OP_SUB_A_B = 8'h90,
    OP_AND_A_B = 8'hA0,
    OP_XOR_A_B = 8'hA8
  } opcode_t;

  // Machine cycle index inside one instruction
  typedef logic [1:0] cycle_count_t;

  localparam int MAX_CYCLES_PER_INSTR = 3;

endpackage

// File: verilog/cpu_system.sv
`timescale 1ns/1ps

module cpu_system #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  logic        load_valid,
  output logic        load_ready,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data,
  output logic        wr_en,
  output logic [15:0] wr_addr,
  output logic [7:0]  wr_data,
  output logic        halted
);

  logic [15:0] addr_bus;
  wire  [7:0]  data_bus;  // Shared tri-state bus
  logic        mmu_req_read;
  logic        mmu_req_write;

  cpu_core cpu_core_inst (
    .clk           (clk),
    .reset         (reset),
    .addr_bus      (addr_bus),
    .data_bus      (data_bus),
    .mmu_req_read  (mmu_req_read),
    .mmu_req_write (mmu_req_write),
    .halted        (halted)
  );

  system_memory #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) system_memory_inst (
    .clk           (clk),
    .reset         (reset),
    .addr_bus      (addr_bus),
    .data_bus      (data_bus),
    .mmu_req_read  (mmu_req_read),
    .mmu_req_write (mmu_req_write),
    .load_valid    (load_valid),
    .load_ready    (load_ready),
    .load_addr     (load_addr),
    .load_data     (load_data),
    .wr_en         (wr_en),
    .wr_addr       (wr_addr),
    .wr_data       (wr_data)
  );

endmodule

// File: verilog/system_memory.sv
`timescale 1ns/1ps

module system_memory #(
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  input  logic        mmu_req_read,
  input  logic        mmu_req_write,
  input  logic        load_valid,
  output logic        load_ready,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data,
  output logic        wr_en,
  output logic [15:0] wr_addr,
  output logic [7:0]  wr_data
);

  localparam int MEM_DEPTH = 1 << MEM_ADDR_WIDTH;

  logic [7:0] mem [MEM_DEPTH];

  logic [MEM_ADDR_WIDTH-1:0] cpu_idx;
  logic [MEM_ADDR_WIDTH-1:0] load_idx;
  logic                      write_seen;  // Request already committed
  logic                      commit;

  assign cpu_idx  = addr_bus[MEM_ADDR_WIDTH-1:0];  // Wraps modulo memory size
  assign load_idx = load_addr[MEM_ADDR_WIDTH-1:0];

  assign data_bus   = mmu_req_read ? mem[cpu_idx] : 8'bz;
  assign load_ready = !mmu_req_read && !mmu_req_write;

  // Request stays up for two edges, commit only on the first
  assign commit = mmu_req_write && !write_seen;

  always_ff @(posedge clk) begin
    if (commit)
      mem[cpu_idx] <= data_bus;
    else if (load_valid && load_ready)
      mem[load_idx] <= load_data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      write_seen <= 1'b0;
      wr_en      <= 1'b0;
    end else begin
      write_seen <= mmu_req_write;
      wr_en      <= commit;  // One-clock pulse per CPU write
    end
  end

  always_ff @(posedge clk) begin
    if (commit) begin
      wr_addr <= 16'(cpu_idx);  // Address of the byte actually written
      wr_data <= data_bus;
    end
  end

endmodule
